// ==== verilog/cpuControlPkg.sv ====
package cpuControlPkg;

	localparam int opcodeWidth = 8;
	localparam int regCount = 14;

	typedef logic [opcodeWidth-1:0] opcode_t;
	typedef logic [regCount-1:0] regMask_t;

	// bit positions inside the write, increment and reset masks
	localparam int regPc = 0;
	localparam int regIr = 1;
	localparam int regGsp = 2;
	localparam int regRp = 3;
	localparam int regCp = 4;
	localparam int regStp = 5;
	localparam int regCid = 6;
	localparam int regEopc = 7;
	localparam int regMc = 8;
	localparam int regMv = 9;
	localparam int regWv = 10;
	localparam int regMulr = 11;
	localparam int regAddr = 12;
	localparam int regAc = 13;

	typedef enum logic [2:0] {aluNone, aluAdd, aluMul, aluDiv, aluMod} aluOp_t;

	typedef enum logic [3:0] {
		bsAc, bsMemOut, bsAddr, bsMulr, bsMv, bsWv, bsCid, bsRp, bsCp, bsStp
	} busSel_t;

	typedef enum logic [1:0] {ptrGsp, ptrStp, ptrRp, ptrCp} ptrSel_t;

	typedef enum logic [1:0] {memIdle, memRead, memWrite} memCtrl_t;

	// opcode entry states sit below 8'h80 and equal their opcode,
	// internal states have the top bit set so no opcode can reach them
	typedef enum logic [opcodeWidth-1:0] {
		rstAll = 8'h01, rstAc = 8'h02, rstAddr = 8'h03, rstGsp = 8'h04,
		rstMc = 8'h05, rstCp = 8'h06, rstRp = 8'h07,
		incGsp = 8'h08, incAc = 8'h09, incCp = 8'h0A, incRp = 8'h0B,
		incMc = 8'h0C, incStp = 8'h0D,
		ldAddr1 = 8'h10, ldAc1 = 8'h11, ldMulr1 = 8'h12, ldRp1 = 8'h13,
		ldCp1 = 8'h14, stSp1 = 8'h15,
		add = 8'h18, mul1 = 8'h19, mul2 = 8'h1A, div = 8'h1B, mod = 8'h1C,
		mStp = 8'h20, mRp = 8'h21, mCp = 8'h22, mWv = 8'h23,
		mEopc = 8'h24, mAddr = 8'h25, mCid = 8'h26, mMv = 8'h27,
		mCidAc = 8'h28, mRpAc = 8'h29, mCpAc = 8'h2A, mStpAc = 8'h2B,
		jz1 = 8'h30, jz2 = 8'h31,
		fetch1 = 8'h80, fetch2 = 8'h81,
		ldAddr2 = 8'h90, ldAc2 = 8'h91, ldMulr2 = 8'h92, ldRp2 = 8'h93,
		ldCp2 = 8'h94, stSp2 = 8'h95,
		jz1Yes1 = 8'hA0, jz1Yes2 = 8'hA1, jz1Yes3 = 8'hA2,
		jz1No1 = 8'hA3, jz1No2 = 8'hA4,
		jz2Yes1 = 8'hA8, jz2Yes2 = 8'hA9, jz2Yes3 = 8'hAA,
		jz2No1 = 8'hAB, jz2No2 = 8'hAC
	} ctrlState_t;

	// unused code, taken in place of any opcode that hits an internal state
	localparam opcode_t opIllegal = 8'h7F;

endpackage

// ==== verilog/controlBus.sv ====
`timescale 1ns/1ps

interface controlBus;

	cpuControlPkg::aluOp_t aluOp;
	cpuControlPkg::busSel_t busSelect;
	cpuControlPkg::ptrSel_t ptrSelect;
	cpuControlPkg::memCtrl_t memCtrl;
	cpuControlPkg::regMask_t wrtEn;
	cpuControlPkg::regMask_t incEn;
	cpuControlPkg::regMask_t rstEn;

	modport decoder (
		output aluOp, busSelect, ptrSelect, memCtrl,
		output wrtEn, incEn, rstEn
	);

	// top level side
	modport sink (
		input aluOp, busSelect, ptrSelect, memCtrl,
		input wrtEn, incEn, rstEn
	);

endinterface

// ==== verilog/controlSequencer.sv ====
`timescale 1ns/1ps

module controlSequencer (
	input logic clk,
	input logic reset,
	input cpuControlPkg::opcode_t ins,
	input logic instrReady,
	input logic dataReady,
	input logic z1,
	input logic z2,
	output logic instrAck,
	output logic dataAck,
	output cpuControlPkg::ctrlState_t state
);

	cpuControlPkg::ctrlState_t nextState;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpuControlPkg::fetch1;
		end else begin
			state <= nextState;
		end
	end

	// execute states, second halves and unknown codes all fall back to fetch1
	always_comb begin
		nextState = cpuControlPkg::fetch1;
		instrAck = 1'b0;
		dataAck = 1'b0;
		case (state)
			cpuControlPkg::fetch1: begin
				instrAck = instrReady;
				nextState = instrReady ? cpuControlPkg::fetch2 : state;
			end
			cpuControlPkg::fetch2: begin
				// opcode value is the entry state
				if (ins[cpuControlPkg::opcodeWidth-1]) begin
					nextState = cpuControlPkg::ctrlState_t'(cpuControlPkg::opIllegal);
				end else begin
					nextState = cpuControlPkg::ctrlState_t'(ins);
				end
			end

			// wait for data memory
			cpuControlPkg::ldAddr1: begin
				dataAck = dataReady;
				nextState = dataReady ? cpuControlPkg::ldAddr2 : state;
			end
			cpuControlPkg::ldAc1: begin
				dataAck = dataReady;
				nextState = dataReady ? cpuControlPkg::ldAc2 : state;
			end
			cpuControlPkg::ldMulr1: begin
				dataAck = dataReady;
				nextState = dataReady ? cpuControlPkg::ldMulr2 : state;
			end
			cpuControlPkg::ldRp1: begin
				dataAck = dataReady;
				nextState = dataReady ? cpuControlPkg::ldRp2 : state;
			end
			cpuControlPkg::ldCp1: begin
				dataAck = dataReady;
				nextState = dataReady ? cpuControlPkg::ldCp2 : state;
			end
			cpuControlPkg::stSp1: begin
				dataAck = dataReady;
				nextState = dataReady ? cpuControlPkg::stSp2 : state;
			end

			// jz1 taken on z1 high
			cpuControlPkg::jz1: begin
				nextState = z1 ? cpuControlPkg::jz1Yes1 : cpuControlPkg::jz1No1;
			end
			cpuControlPkg::jz1Yes1: begin
				instrAck = instrReady;
				nextState = instrReady ? cpuControlPkg::jz1Yes2 : state;
			end
			cpuControlPkg::jz1Yes2: begin
				nextState = cpuControlPkg::jz1Yes3;
			end
			cpuControlPkg::jz1No1: begin
				nextState = cpuControlPkg::jz1No2;
			end

			// jz2 taken on z2 low
			cpuControlPkg::jz2: begin
				nextState = z2 ? cpuControlPkg::jz2No1 : cpuControlPkg::jz2Yes1;
			end
			cpuControlPkg::jz2Yes1: begin
				instrAck = instrReady;
				nextState = instrReady ? cpuControlPkg::jz2Yes2 : state;
			end
			cpuControlPkg::jz2Yes2: begin
				nextState = cpuControlPkg::jz2Yes3;
			end
			cpuControlPkg::jz2No1: begin
				nextState = cpuControlPkg::jz2No2;
			end

			default: begin
				nextState = cpuControlPkg::fetch1;
			end
		endcase
	end

endmodule

// ==== verilog/controlWordDecoder.sv ====
`timescale 1ns/1ps

module controlWordDecoder (
	input cpuControlPkg::ctrlState_t state,
	controlBus.decoder ctrl
);

	always_comb begin
		// idle word, each state overrides what it needs
		ctrl.aluOp = cpuControlPkg::aluNone;
		ctrl.busSelect = cpuControlPkg::bsAc;
		ctrl.ptrSelect = cpuControlPkg::ptrGsp;
		ctrl.memCtrl = cpuControlPkg::memIdle;
		ctrl.wrtEn = '0;
		ctrl.incEn = '0;
		ctrl.rstEn = '0;
		case (state)
			cpuControlPkg::fetch1: ctrl.ptrSelect = cpuControlPkg::ptrStp;
			cpuControlPkg::fetch2: begin
				ctrl.incEn[cpuControlPkg::regPc] = 1'b1;
				ctrl.wrtEn[cpuControlPkg::regIr] = 1'b1;
			end

			// everything but PC and IR
			cpuControlPkg::rstAll: begin
				ctrl.rstEn = '1;
				ctrl.rstEn[cpuControlPkg::regPc] = 1'b0;
				ctrl.rstEn[cpuControlPkg::regIr] = 1'b0;
			end
			cpuControlPkg::rstAc: ctrl.rstEn[cpuControlPkg::regAc] = 1'b1;
			cpuControlPkg::rstAddr: ctrl.rstEn[cpuControlPkg::regAddr] = 1'b1;
			cpuControlPkg::rstGsp: ctrl.rstEn[cpuControlPkg::regGsp] = 1'b1;
			cpuControlPkg::rstMc: ctrl.rstEn[cpuControlPkg::regMc] = 1'b1;
			cpuControlPkg::rstCp: ctrl.rstEn[cpuControlPkg::regCp] = 1'b1;
			cpuControlPkg::rstRp: ctrl.rstEn[cpuControlPkg::regRp] = 1'b1;

			cpuControlPkg::incGsp: ctrl.incEn[cpuControlPkg::regGsp] = 1'b1;
			cpuControlPkg::incAc: ctrl.incEn[cpuControlPkg::regAc] = 1'b1;
			cpuControlPkg::incCp: ctrl.incEn[cpuControlPkg::regCp] = 1'b1;
			cpuControlPkg::incRp: ctrl.incEn[cpuControlPkg::regRp] = 1'b1;
			cpuControlPkg::incMc: ctrl.incEn[cpuControlPkg::regMc] = 1'b1;
			cpuControlPkg::incStp: ctrl.incEn[cpuControlPkg::regStp] = 1'b1;

			cpuControlPkg::ldAddr1, cpuControlPkg::ldAc1, cpuControlPkg::ldMulr1: begin
				ctrl.memCtrl = cpuControlPkg::memRead;
			end
			cpuControlPkg::ldRp1: begin
				ctrl.memCtrl = cpuControlPkg::memRead;
				ctrl.ptrSelect = cpuControlPkg::ptrRp;
			end
			cpuControlPkg::ldCp1: begin
				ctrl.memCtrl = cpuControlPkg::memRead;
				ctrl.ptrSelect = cpuControlPkg::ptrCp;
			end
			cpuControlPkg::ldAddr2: begin
				ctrl.busSelect = cpuControlPkg::bsMemOut;
				ctrl.wrtEn[cpuControlPkg::regAddr] = 1'b1;
			end
			// rp load lands in MULR, cp load in AC
			cpuControlPkg::ldAc2, cpuControlPkg::ldCp2: begin
				ctrl.busSelect = cpuControlPkg::bsMemOut;
				ctrl.wrtEn[cpuControlPkg::regAc] = 1'b1;
			end
			cpuControlPkg::ldMulr2, cpuControlPkg::ldRp2: begin
				ctrl.busSelect = cpuControlPkg::bsMemOut;
				ctrl.wrtEn[cpuControlPkg::regMulr] = 1'b1;
			end

			cpuControlPkg::stSp1: ctrl.ptrSelect = cpuControlPkg::ptrStp;
			cpuControlPkg::stSp2: begin
				ctrl.ptrSelect = cpuControlPkg::ptrStp;
				ctrl.memCtrl = cpuControlPkg::memWrite;
			end

			cpuControlPkg::add: begin
				ctrl.aluOp = cpuControlPkg::aluAdd;
				ctrl.busSelect = cpuControlPkg::bsAddr;
			end
			cpuControlPkg::mul1: begin
				ctrl.aluOp = cpuControlPkg::aluMul;
				ctrl.busSelect = cpuControlPkg::bsMulr;
			end
			cpuControlPkg::mul2: begin
				ctrl.aluOp = cpuControlPkg::aluMul;
				ctrl.busSelect = cpuControlPkg::bsMv;
			end
			cpuControlPkg::div: begin
				ctrl.aluOp = cpuControlPkg::aluDiv;
				ctrl.busSelect = cpuControlPkg::bsWv;
			end
			cpuControlPkg::mod: begin
				ctrl.aluOp = cpuControlPkg::aluMod;
				ctrl.busSelect = cpuControlPkg::bsWv;
			end

			// moves out of AC, bus stays on AC
			cpuControlPkg::mStp: ctrl.wrtEn[cpuControlPkg::regStp] = 1'b1;
			cpuControlPkg::mRp: ctrl.wrtEn[cpuControlPkg::regRp] = 1'b1;
			cpuControlPkg::mCp: ctrl.wrtEn[cpuControlPkg::regCp] = 1'b1;
			cpuControlPkg::mWv: ctrl.wrtEn[cpuControlPkg::regWv] = 1'b1;
			cpuControlPkg::mEopc: ctrl.wrtEn[cpuControlPkg::regEopc] = 1'b1;
			cpuControlPkg::mAddr: ctrl.wrtEn[cpuControlPkg::regAddr] = 1'b1;
			cpuControlPkg::mCid: ctrl.wrtEn[cpuControlPkg::regCid] = 1'b1;
			cpuControlPkg::mMv: ctrl.wrtEn[cpuControlPkg::regMv] = 1'b1;

			cpuControlPkg::mCidAc, cpuControlPkg::mRpAc, cpuControlPkg::mCpAc,
			cpuControlPkg::mStpAc: begin
				ctrl.wrtEn[cpuControlPkg::regAc] = 1'b1;
				case (state)
					cpuControlPkg::mCidAc: ctrl.busSelect = cpuControlPkg::bsCid;
					cpuControlPkg::mRpAc: ctrl.busSelect = cpuControlPkg::bsRp;
					cpuControlPkg::mCpAc: ctrl.busSelect = cpuControlPkg::bsCp;
					default: ctrl.busSelect = cpuControlPkg::bsStp;
				endcase
			end

			// jump target fetch, then PC load
			cpuControlPkg::jz1Yes1, cpuControlPkg::jz2Yes1: ctrl.wrtEn[cpuControlPkg::regIr] = 1'b1;
			cpuControlPkg::jz1Yes2, cpuControlPkg::jz2Yes2: ctrl.wrtEn[cpuControlPkg::regPc] = 1'b1;
			cpuControlPkg::jz1No1, cpuControlPkg::jz2No1: begin
				ctrl.incEn[cpuControlPkg::regPc] = 1'b1;
				ctrl.wrtEn[cpuControlPkg::regIr] = 1'b1;
			end

			default: ctrl.aluOp = cpuControlPkg::aluNone;
		endcase
	end

endmodule

// ==== verilog/cpuControl.sv ====
`timescale 1ns/1ps

module cpuControl (
	input logic clk,
	input logic reset,
	input cpuControlPkg::opcode_t ins,
	input logic instrReady,
	input logic dataReady,
	input logic z1,
	input logic z2,
	output cpuControlPkg::aluOp_t aluOp,
	output cpuControlPkg::busSel_t busSelect,
	output cpuControlPkg::ptrSel_t ptrSelect,
	output cpuControlPkg::memCtrl_t memCtrl,
	output cpuControlPkg::regMask_t wrtEn,
	output cpuControlPkg::regMask_t incEn,
	output cpuControlPkg::regMask_t rstEn,
	output logic instrAck,
	output logic dataAck
);

	cpuControlPkg::ctrlState_t state;

	controlBus ctrlBus ();

	controlSequencer u_sequencer (
		.clk        (clk),
		.reset      (reset),
		.ins        (ins),
		.instrReady (instrReady),
		.dataReady  (dataReady),
		.z1         (z1),
		.z2         (z2),
		.instrAck   (instrAck),
		.dataAck    (dataAck),
		.state      (state)
	);

	controlWordDecoder u_decoder (
		.state (state),
		.ctrl  (ctrlBus.decoder)
	);

	// control word straight from the state register
	assign aluOp = ctrlBus.aluOp;
	assign busSelect = ctrlBus.busSelect;
	assign ptrSelect = ctrlBus.ptrSelect;
	assign memCtrl = ctrlBus.memCtrl;
	assign wrtEn = ctrlBus.wrtEn;
	assign incEn = ctrlBus.incEn;
	assign rstEn = ctrlBus.rstEn;

endmodule

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic clk
);

	// 100 ns period
	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

endmodule

// ==== testbench/cpuControl_assertions.sv ====
`timescale 1ns/1ps

module cpuControlAssertions (
	input logic clk,
	input logic reset,
	input logic instrAck,
	input logic dataAck,
	input cpuControlPkg::memCtrl_t memCtrl,
	input cpuControlPkg::regMask_t wrtEn,
	input cpuControlPkg::ctrlState_t state
);

	// number of failed assertions so far
	int errorCount = 0;

	// acks are single-cycle pulses
	instrAckPulse: assert property (@(posedge clk) disable iff (reset) instrAck |=> !instrAck)
		else begin
			$error("instrAck stayed high for two cycles");
			errorCount++;
		end
	dataAckPulse: assert property (@(posedge clk) disable iff (reset) dataAck |=> !dataAck)
		else begin
			$error("dataAck stayed high for two cycles");
			errorCount++;
		end

	// read and write never at once
	memCtrlLegal: assert property (@(posedge clk) disable iff (reset)
		memCtrl inside {cpuControlPkg::memIdle, cpuControlPkg::memRead, cpuControlPkg::memWrite})
		else begin
			$error("memCtrl has an illegal value");
			errorCount++;
		end

	fetchNoWrite: assert property (@(posedge clk) disable iff (reset)
		state == cpuControlPkg::fetch1 |-> wrtEn == '0)
		else begin
			$error("write mask active in fetch1");
			errorCount++;
		end

endmodule

// ==== testbench/cpuControlTb.sv ====
`timescale 1ns/1ps

module cpuControlTb;

	logic clk;
	logic reset;
	cpuControlPkg::opcode_t ins;
	logic instrReady, dataReady, z1, z2;
	cpuControlPkg::aluOp_t aluOp;
	cpuControlPkg::busSel_t busSelect;
	cpuControlPkg::ptrSel_t ptrSelect;
	cpuControlPkg::memCtrl_t memCtrl;
	cpuControlPkg::regMask_t wrtEn, incEn, rstEn;
	logic instrAck, dataAck;

	// test table with one entry per data line and the steps flattened
	string testNames[$];
	logic [7:0] testOps[$];
	logic testZ1[$], testZ2[$];
	int testDelays[$], testSteps[$], stepKinds[$];
	logic [63:0] stepWords[$];

	// fetch1 word in the data file layout has only ptrStp set
	logic [63:0] fetchWord = 64'h0010000000000000;
	int unsigned lcgState = 61;
	int cycleCount = 0;
	int cycleLimit = 0;
	int testErrors, passedTests, failedTests;
	string curName;
	logic [7:0] curOp;
	logic curZ1, curZ2;

	clockGen u_clockGen (.clk(clk));

	cpuControl u_cpuControl (
		.clk(clk), .reset(reset), .ins(ins), .instrReady(instrReady),
		.dataReady(dataReady), .z1(z1), .z2(z2), .aluOp(aluOp),
		.busSelect(busSelect), .ptrSelect(ptrSelect), .memCtrl(memCtrl),
		.wrtEn(wrtEn), .incEn(incEn), .rstEn(rstEn),
		.instrAck(instrAck), .dataAck(dataAck)
	);

	bind cpuControl cpuControlAssertions u_assertions (
		.clk(clk), .reset(reset), .instrAck(instrAck), .dataAck(dataAck),
		.memCtrl(memCtrl), .wrtEn(wrtEn), .state(state)
	);

	// delay of 0 to 3 cycles before a ready level rises
	function automatic int unsigned randomDelay();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return (lcgState >> 16) % 4;
	endfunction

	// drive on the falling edge and check once the inputs have settled
	task automatic stepCycle(input logic [63:0] expWord, input logic instrLevel,
			input logic dataLevel);
		logic [63:0] actual;
		@(negedge clk);
		ins = curOp;
		z1 = curZ1;
		z2 = curZ2;
		instrReady = instrLevel;
		dataReady = dataLevel;
		#10;
		actual = {1'b0, aluOp, busSelect, 2'b00, ptrSelect, 2'b00, memCtrl,
			2'b00, wrtEn, 2'b00, incEn, 2'b00, rstEn};
		assert (actual === expWord) else begin
			$display("[FAIL] %s: control word expected %h, actual %h", curName, expWord, actual);
			testErrors++;
		end
		assert (instrAck === instrLevel) else begin
			$display("[FAIL] %s: instrAck expected %b, actual %b", curName, instrLevel, instrAck);
			testErrors++;
		end
		assert (dataAck === dataLevel) else begin
			$display("[FAIL] %s: dataAck expected %b, actual %b", curName, dataLevel, dataAck);
			testErrors++;
		end
	endtask

	// kind 1 waits on dataReady, kind 2 on instrReady
	task automatic waitStep(input logic [63:0] expWord, input int kind, input int lowCycles);
		repeat (lowCycles) stepCycle(expWord, 1'b0, 1'b0);
		stepCycle(expWord, kind == 2, kind == 1);
	endtask

	// one result line per finished test
	task automatic finishTest();
		if (testErrors == 0) begin
			$display("%s: passed", curName);
			passedTests++;
		end else begin
			$display("%s: failed with %0d errors", curName, testErrors);
			failedTests++;
		end
	endtask

	task automatic loadTests(output bit loaded);
		int fd, code, count, kind, delay;
		string tok;
		logic [8*200-1:0] skipped;
		logic [63:0] word;
		logic [7:0] op;
		logic fz1, fz2;
		loaded = 1'b0;
		fd = $fopen("testbench/cpuControl_testdata.txt", "r");
		if (fd != 0) begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					code = $fgets(skipped, fd);
				end else begin
					code = $fscanf(fd, "%h %h %h %d %d", op, fz1, fz2, delay, count);
					testNames.push_back(tok);
					testOps.push_back(op);
					testZ1.push_back(fz1);
					testZ2.push_back(fz2);
					testDelays.push_back(delay);
					testSteps.push_back(count);
					for (int i = 0; i < count; i++) begin
						code = $fscanf(fd, "%h %h", kind, word);
						stepKinds.push_back(kind);
						stepWords.push_back(word);
					end
				end
			end
			$fclose(fd);
			loaded = testNames.size() > 0;
		end
	endtask

	initial begin
		int first;
		int assertErrors;
		bit loaded;
		reset = 1'b1;
		ins = '0;
		instrReady = 1'b0;
		dataReady = 1'b0;
		z1 = 1'b0;
		z2 = 1'b0;
		curOp = '0;
		curZ1 = 1'b0;
		curZ2 = 1'b0;
		testErrors = 0;
		passedTests = 0;
		failedTests = 0;
		loadTests(loaded);
		// reset and three hold cycles, then per test the fetch wait, steps, waits and return
		cycleLimit = 13;
		foreach (testSteps[t]) cycleLimit += testSteps[t] + testDelays[t] + 8;
		cycleLimit *= 2;
		repeat (10) @(negedge clk);
		reset = 1'b0;
		if (!loaded) begin
			$display("test data file could not be read, no tests were run");
		end else begin
			// fetch1 keeps its word and instrAck stays low while instrReady is low
			curName = "resetHold";
			testErrors = 0;
			repeat (3) stepCycle(fetchWord, 1'b0, 1'b0);
			finishTest();
			first = 0;
			foreach (testNames[t]) begin
				curName = testNames[t];
				curOp = testOps[t];
				curZ1 = testZ1[t];
				curZ2 = testZ2[t];
				testErrors = 0;
				waitStep(fetchWord, 2, randomDelay());
				for (int s = 0; s < testSteps[t]; s++) begin
					case (stepKinds[first + s])
						1: waitStep(stepWords[first + s], 1, testDelays[t]);
						2: waitStep(stepWords[first + s], 2, randomDelay());
						default: stepCycle(stepWords[first + s], 1'b0, 1'b0);
					endcase
				end
				stepCycle(fetchWord, 1'b0, 1'b0);
				first += testSteps[t];
				finishTest();
			end
		end
		assertErrors = u_cpuControl.u_assertions.errorCount;
		$display("%0d tests run, %0d passed, %0d failed, %0d assertion failures",
			passedTests + failedTests, passedTests, failedTests, assertErrors);
		if (loaded && failedTests == 0 && assertErrors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin
		wait (cycleLimit != 0);
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout after %0d cycles, the DUT stopped making progress", cycleCount);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== cpuControl.f ====
verilog/cpuControlPkg.sv
verilog/controlBus.sv
verilog/controlSequencer.sv
verilog/controlWordDecoder.sv
verilog/cpuControl.sv
testbench/clockGen.sv
testbench/cpuControl_assertions.sv
testbench/cpuControlTb.sv

// ==== Bender.yml ====
package:
  name: cpuControl

sources:
  - verilog/cpuControlPkg.sv
  - verilog/controlBus.sv
  - verilog/controlSequencer.sv
  - verilog/controlWordDecoder.sv
  - verilog/cpuControl.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/cpuControl_assertions.sv
      - testbench/cpuControlTb.sv

// ==== testbench/cpuControl_testdata.txt ====
# name opcode z1 z2 dataDelay steps, then per step a wait kind (0 none 1 data 2 instr) and a word
# word digits: aluOp busSelect ptrSelect memCtrl, then wrtEn incEn rstEn with four digits each
rstAll 01 0 0 0 2 0 0000000200010000 0 0000000000003ffc
incStp 0d 0 0 0 2 0 0000000200010000 0 0000000000200000
mEopc 24 0 0 0 2 0 0000000200010000 0 0000008000000000
mCpAc 2a 0 0 0 2 0 0000000200010000 0 0800200000000000
ldCp 14 0 0 3 3 0 0000000200010000 1 0031000000000000 0 0100200000000000
ldRp 13 0 0 1 3 0 0000000200010000 1 0021000000000000 0 0100080000000000
ldAddr 10 0 0 0 3 0 0000000200010000 1 0001000000000000 0 0100100000000000
stSp 15 0 0 2 3 0 0000000200010000 1 0010000000000000 0 0012000000000000
add 18 0 0 0 2 0 0000000200010000 0 1200000000000000
mul1 19 0 0 0 2 0 0000000200010000 0 2300000000000000
mul2 1a 0 0 0 2 0 0000000200010000 0 2400000000000000
div 1b 0 0 0 2 0 0000000200010000 0 3500000000000000
mod 1c 0 0 0 2 0 0000000200010000 0 4500000000000000
jz1Taken 30 1 0 0 5 0 0000000200010000 0 0000000000000000 2 0000000200000000
	0 0000000100000000 0 0000000000000000
jz1NotTaken 30 0 0 0 4 0 0000000200010000 0 0000000000000000
	0 0000000200010000 0 0000000000000000
jz2Taken 31 0 0 0 5 0 0000000200010000 0 0000000000000000 2 0000000200000000
	0 0000000100000000 0 0000000000000000
jz2NotTaken 31 0 1 0 4 0 0000000200010000 0 0000000000000000
	0 0000000200010000 0 0000000000000000
